//--- design/if_pkg.sv
/*
 * Shared types and constants for the instruction fetch stage.
 * Imported by every RTL module of the stage.
 */

`default_nettype none

package if_pkg;

  // basic word types
  typedef logic [31:0] addr_t;
  typedef logic [31:0] instr_t;
  typedef logic [4:0]  irq_id_t;

  // fetch address source on a redirect
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // trap target, only looked at for PC_EXC
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

  // debug module entry points
  localparam addr_t DM_HALT_ADDR      = 32'h1A11_0800;
  localparam addr_t DM_EXCEPTION_ADDR = 32'h1A11_0808;

  // first instruction sits 0x80 into the 256-byte boot region
  localparam logic [7:0] BOOT_OFFSET = 8'h80;
  // low address bits supplied by the select logic, not by the base register
  localparam int unsigned VEC_ALIGN_BITS = 8;

  // every instruction is one aligned word
  localparam int unsigned INSTR_BYTES = 4;
  // queue depth, also the cap on requests in flight
  localparam int unsigned FIFO_DEPTH = 2;

endpackage

`default_nettype wire

//--- design/pc_select.sv
/*
 * Next fetch address select for redirects, plus the trap vector mux.
 * Purely combinational, sits in front of the fetch unit.
 */

`timescale 1ns/1ps
`default_nettype none

module pc_select import if_pkg::*; (
  input  pc_sel_e     pc_mux_i,
  input  exc_pc_sel_e exc_pc_mux_i,
  input  irq_id_t     exc_irq_id_i,
  input  addr_t       boot_addr_i,
  input  addr_t       branch_target_i,
  input  addr_t       csr_mepc_i,
  input  addr_t       csr_depc_i,
  input  addr_t       csr_mtvec_i,
  input  logic        pc_set_i,
  output addr_t       fetch_addr_o,
  output logic        csr_mtvec_init_o
);

  addr_t exc_pc;
  addr_t boot_pc;

  // boot region base with fixed entry offset
  assign boot_pc = {boot_addr_i[31:VEC_ALIGN_BITS], BOOT_OFFSET};

  //////////////////////////////////////////////////
  // trap vector
  //////////////////////////////////////////////////

  always_comb begin
    unique case (exc_pc_mux_i)
      EXC_PC_EXC:     exc_pc = {csr_mtvec_i[31:VEC_ALIGN_BITS], {VEC_ALIGN_BITS{1'b0}}};
      // vectored mode, one word per interrupt line
      EXC_PC_IRQ:     exc_pc = {csr_mtvec_i[31:VEC_ALIGN_BITS], 1'b0, exc_irq_id_i, 2'b00};
      EXC_PC_DBD:     exc_pc = DM_HALT_ADDR;
      EXC_PC_DBG_EXC: exc_pc = DM_EXCEPTION_ADDR;
      default:        exc_pc = {csr_mtvec_i[31:VEC_ALIGN_BITS], {VEC_ALIGN_BITS{1'b0}}};
    endcase
  end

  //////////////////////////////////////////////////
  // fetch address
  //////////////////////////////////////////////////

  always_comb begin
    unique case (pc_mux_i)
      PC_BOOT: fetch_addr_o = boot_pc;
      PC_JUMP: fetch_addr_o = branch_target_i;
      PC_EXC:  fetch_addr_o = exc_pc;
      // return from trap / debug mode
      PC_ERET: fetch_addr_o = csr_mepc_i;
      PC_DRET: fetch_addr_o = csr_depc_i;
      default: fetch_addr_o = boot_pc;
    endcase
  end

  // csr file loads its mtvec reset value on the boot jump
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == PC_BOOT);

endmodule

`default_nettype wire

//--- design/fetch_unit.sv
/*
 * Instruction bus master. Issues word requests, tracks the ones in flight
 * and pairs each response with its address before it goes to the queue.
 */

`timescale 1ns/1ps
`default_nettype none

module fetch_unit import if_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       req_i,
  input  logic       pc_set_i,
  input  addr_t      redirect_addr_i,
  input  logic [1:0] free_slots_i,
  output logic       instr_req_o,
  output addr_t      instr_addr_o,
  input  logic       instr_gnt_i,
  input  logic       instr_rvalid_i,
  input  instr_t     instr_rdata_i,
  input  logic       instr_bus_err_i,
  output logic       wr_o,
  output addr_t      wr_addr_o,
  output instr_t     wr_data_o,
  output logic       wr_err_o,
  output logic       flush_o,
  output logic       busy_o
);

  addr_t                 fetch_addr_q;
  logic                  started_q;
  logic                  issue;
  logic [1:0]            out_cnt_q, out_cnt_d;
  addr_t                 out_addr_q [FIFO_DEPTH];
  addr_t                 out_addr_d [FIFO_DEPTH];
  logic [FIFO_DEPTH-1:0] out_disc_q, out_disc_d;

  //////////////////////////////////////////////////
  // request side
  //////////////////////////////////////////////////

  // in-flight plus stored must stay below the queue depth
  assign instr_req_o  = req_i & started_q & (out_cnt_q < free_slots_i);
  assign instr_addr_o = fetch_addr_q;
  assign issue        = instr_req_o & instr_gnt_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_addr_q <= '0;
      started_q    <= 1'b0;
    end else if (pc_set_i) begin
      // redirect wins over a grant of the old address
      fetch_addr_q <= {redirect_addr_i[31:2], 2'b00};
      started_q    <= 1'b1;
    end else if (issue) begin
      fetch_addr_q <= fetch_addr_q + addr_t'(INSTR_BYTES);
    end
  end

  //////////////////////////////////////////////////
  // outstanding queue, oldest entry at index 0
  //////////////////////////////////////////////////

  always_comb begin
    out_cnt_d  = out_cnt_q;
    out_addr_d = out_addr_q;
    out_disc_d = out_disc_q;
    // everything still in flight belongs to the old stream
    if (pc_set_i) begin
      out_disc_d = '1;
    end
    // responses are in order, retire the head
    if (instr_rvalid_i) begin
      for (int i = 0; i < FIFO_DEPTH - 1; i++) begin
        out_addr_d[i] = out_addr_d[i+1];
        out_disc_d[i] = out_disc_d[i+1];
      end
      out_cnt_d = out_cnt_d - 2'd1;
    end
    // append behind what is left, a grant during a redirect is dropped later
    if (issue) begin
      out_addr_d[out_cnt_d[0]] = fetch_addr_q;
      out_disc_d[out_cnt_d[0]] = pc_set_i;
      out_cnt_d                = out_cnt_d + 2'd1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_cnt_q  <= '0;
      out_disc_q <= '0;
    end else begin
      out_cnt_q  <= out_cnt_d;
      out_disc_q <= out_disc_d;
    end
  end

  always_ff @(posedge clk_i) begin
    out_addr_q <= out_addr_d;
  end

  //////////////////////////////////////////////////
  // response side
  //////////////////////////////////////////////////

  // stale words never reach the queue
  assign wr_o      = instr_rvalid_i & ~out_disc_q[0] & ~pc_set_i;
  assign wr_addr_o = out_addr_q[0];
  assign wr_data_o = instr_rdata_i;
  assign wr_err_o  = instr_bus_err_i;
  assign flush_o   = pc_set_i;
  assign busy_o    = (out_cnt_q != 2'd0);

endmodule

`default_nettype wire

//--- design/fetch_fifo.sv
/*
 * Small queue between the bus and the IF-ID register.
 * Holds fetched address, word and error; head is always at entry 0.
 */

`timescale 1ns/1ps
`default_nettype none

module fetch_fifo import if_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       wr_i,
  input  addr_t      wr_addr_i,
  input  instr_t     wr_data_i,
  input  logic       wr_err_i,
  input  logic       flush_i,
  input  logic       pop_i,
  output logic       out_valid_o,
  output addr_t      out_addr_o,
  output instr_t     out_data_o,
  output logic       out_err_o,
  output logic [1:0] free_slots_o
);

  logic [1:0]            cnt_q, cnt_d;
  logic                  pop;
  addr_t                 addr_q [FIFO_DEPTH];
  addr_t                 addr_d [FIFO_DEPTH];
  instr_t                data_q [FIFO_DEPTH];
  instr_t                data_d [FIFO_DEPTH];
  logic [FIFO_DEPTH-1:0] err_q, err_d;

  // pop on an empty queue is ignored
  assign pop = pop_i & (cnt_q != 2'd0);

  always_comb begin
    cnt_d  = cnt_q;
    addr_d = addr_q;
    data_d = data_q;
    err_d  = err_q;
    // shift the head out first
    if (pop) begin
      for (int i = 0; i < FIFO_DEPTH - 1; i++) begin
        addr_d[i] = addr_d[i+1];
        data_d[i] = data_d[i+1];
        err_d[i]  = err_d[i+1];
      end
      cnt_d = cnt_d - 2'd1;
    end
    // then push into the first free entry
    if (wr_i) begin
      addr_d[cnt_d[0]] = wr_addr_i;
      data_d[cnt_d[0]] = wr_data_i;
      err_d[cnt_d[0]]  = wr_err_i;
      cnt_d            = cnt_d + 2'd1;
    end
    if (flush_i) begin
      cnt_d = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    addr_q <= addr_d;
    data_q <= data_d;
    err_q  <= err_d;
  end

  // flush hides the head in the same cycle
  assign out_valid_o  = (cnt_q != 2'd0) & ~flush_i;
  assign out_addr_o   = addr_q[0];
  assign out_data_o   = data_q[0];
  assign out_err_o    = err_q[0];
  assign free_slots_o = 2'(FIFO_DEPTH) - cnt_q;

endmodule

`default_nettype wire

//--- design/if_id_reg.sv
/*
 * IF-ID pipeline register. Loads the queue head when decode is ready,
 * keeps valid until cleared and flags each freshly loaded instruction.
 */

`timescale 1ns/1ps
`default_nettype none

module if_id_reg import if_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   valid_i,
  input  addr_t  addr_i,
  input  instr_t data_i,
  input  logic   err_i,
  input  logic   id_in_ready_i,
  input  logic   pc_set_i,
  input  logic   instr_valid_clear_i,
  output logic   pop_o,
  output logic   load_o,
  output logic   instr_valid_id_o,
  output logic   instr_new_id_o,
  output instr_t instr_rdata_id_o,
  output logic   instr_fetch_err_o,
  output addr_t  pc_id_o
);

  logic load;
  logic valid_d;

  assign load   = valid_i & id_in_ready_i;
  assign pop_o  = load;
  assign load_o = load;

  // a load squashed by a redirect does not make decode valid
  assign valid_d = (load & ~pc_set_i) | (instr_valid_id_o & ~instr_valid_clear_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_valid_id_o <= 1'b0;
      instr_new_id_o   <= 1'b0;
    end else begin
      instr_valid_id_o <= valid_d;
      // one-cycle marker after every load
      instr_new_id_o   <= load;
    end
  end

  // word, error and PC frozen while decode stalls
  always_ff @(posedge clk_i) begin
    if (load) begin
      instr_rdata_id_o  <= data_i;
      instr_fetch_err_o <= err_i;
      pc_id_o           <= addr_i;
    end
  end

endmodule

`default_nettype wire

//--- design/pc_check.sv
/*
 * PC consistency monitor. Raises an alert, one cycle late, when two loads
 * in a row without redirect or error do not step the PC by one word.
 */

`timescale 1ns/1ps
`default_nettype none

module pc_check import if_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  load_i,
  input  logic  pc_set_i,
  input  logic  fetch_err_i,
  input  addr_t pc_if_i,
  input  addr_t pc_id_i,
  output logic  pc_mismatch_alert_o
);

  logic seq_q, seq_d;
  logic mismatch;

  // stream counts as sequential after a load, until redirect or fetch error
  assign seq_d = (seq_q | load_i) & ~pc_set_i & ~fetch_err_i;

  // expected PC is the one in decode plus a word
  assign mismatch = (pc_if_i != (pc_id_i + addr_t'(INSTR_BYTES)));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seq_q               <= 1'b0;
      pc_mismatch_alert_o <= 1'b0;
    end else begin
      seq_q               <= seq_d;
      pc_mismatch_alert_o <= load_i & ~pc_set_i & seq_q & mismatch;
    end
  end

endmodule

`default_nettype wire

//--- design/if_stage.sv
/*
 * Instruction fetch stage top. Connects address select, bus master,
 * fetch queue, IF-ID register and the PC consistency check.
 */

`timescale 1ns/1ps
`default_nettype none

module if_stage import if_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        req_i,
  input  addr_t       boot_addr_i,
  // redirect control from the controller
  input  logic        pc_set_i,
  input  pc_sel_e     pc_mux_i,
  input  exc_pc_sel_e exc_pc_mux_i,
  input  irq_id_t     exc_irq_id_i,
  input  addr_t       branch_target_i,
  input  addr_t       csr_mepc_i,
  input  addr_t       csr_depc_i,
  input  addr_t       csr_mtvec_i,
  output logic        csr_mtvec_init_o,
  // instruction bus
  output logic        instr_req_o,
  output addr_t       instr_addr_o,
  input  logic        instr_gnt_i,
  input  logic        instr_rvalid_i,
  input  instr_t      instr_rdata_i,
  input  logic        instr_bus_err_i,
  // decode side
  input  logic        id_in_ready_i,
  input  logic        instr_valid_clear_i,
  output logic        instr_valid_id_o,
  output logic        instr_new_id_o,
  output instr_t      instr_rdata_id_o,
  output logic        instr_fetch_err_o,
  output addr_t       pc_id_o,
  output addr_t       pc_if_o,
  output logic        if_busy_o,
  output logic        pc_mismatch_alert_o
);

  addr_t      fetch_addr;
  logic [1:0] free_slots;
  logic       wr, wr_err, flush;
  addr_t      wr_addr;
  instr_t     wr_data, out_data;
  logic       out_valid, out_err;
  logic       pop, load;

  pc_select u_pc_select (
    .pc_mux_i        (pc_mux_i),
    .exc_pc_mux_i    (exc_pc_mux_i),
    .exc_irq_id_i    (exc_irq_id_i),
    .boot_addr_i     (boot_addr_i),
    .branch_target_i (branch_target_i),
    .csr_mepc_i      (csr_mepc_i),
    .csr_depc_i      (csr_depc_i),
    .csr_mtvec_i     (csr_mtvec_i),
    .pc_set_i        (pc_set_i),
    .fetch_addr_o    (fetch_addr),
    .csr_mtvec_init_o(csr_mtvec_init_o)
  );

  fetch_unit u_fetch_unit (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .pc_set_i       (pc_set_i),
    .redirect_addr_i(fetch_addr),
    .free_slots_i   (free_slots),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_bus_err_i(instr_bus_err_i),
    .wr_o           (wr),
    .wr_addr_o      (wr_addr),
    .wr_data_o      (wr_data),
    .wr_err_o       (wr_err),
    .flush_o        (flush),
    .busy_o         (if_busy_o)
  );

  // queue head doubles as the IF-stage PC
  fetch_fifo u_fetch_fifo (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .wr_i        (wr),
    .wr_addr_i   (wr_addr),
    .wr_data_i   (wr_data),
    .wr_err_i    (wr_err),
    .flush_i     (flush),
    .pop_i       (pop),
    .out_valid_o (out_valid),
    .out_addr_o  (pc_if_o),
    .out_data_o  (out_data),
    .out_err_o   (out_err),
    .free_slots_o(free_slots)
  );

  if_id_reg u_if_id_reg (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .valid_i            (out_valid),
    .addr_i             (pc_if_o),
    .data_i             (out_data),
    .err_i              (out_err),
    .id_in_ready_i      (id_in_ready_i),
    .pc_set_i           (pc_set_i),
    .instr_valid_clear_i(instr_valid_clear_i),
    .pop_o              (pop),
    .load_o             (load),
    .instr_valid_id_o   (instr_valid_id_o),
    .instr_new_id_o     (instr_new_id_o),
    .instr_rdata_id_o   (instr_rdata_id_o),
    .instr_fetch_err_o  (instr_fetch_err_o),
    .pc_id_o            (pc_id_o)
  );

  pc_check u_pc_check (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .load_i             (load),
    .pc_set_i           (pc_set_i),
    .fetch_err_i        (out_err),
    .pc_if_i            (pc_if_o),
    .pc_id_i            (pc_id_o),
    .pc_mismatch_alert_o(pc_mismatch_alert_o)
  );

endmodule

`default_nettype wire

//--- test/if_stage_assertions.sv
/*
 * Instruction bus rules for the fetch stage, bound into the top level.
 */

`timescale 1ns/1ps
`default_nettype none

module if_stage_assertions import if_pkg::*; (
  input wire logic  clk_i,
  input wire logic  rst_ni,
  input wire logic  pc_set_i,
  input wire logic  instr_req_o,
  input wire addr_t instr_addr_o,
  input wire logic  instr_gnt_i,
  input wire logic  instr_rvalid_i
);

  int outstanding;

  // granted minus answered
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + int'(instr_req_o & instr_gnt_i) - int'(instr_rvalid_i);
    end
  end

  addr_ok: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o |-> (!$isunknown(instr_addr_o) && instr_addr_o[1:0] == 2'b00))
    else $error("fetch address unknown or not word aligned");

  addr_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (instr_req_o && !instr_gnt_i && !pc_set_i) |=> (instr_req_o && $stable(instr_addr_o)))
    else $error("request dropped or address changed before grant");

  max_inflight: assert property (@(posedge clk_i) disable iff (!rst_ni)
    outstanding <= FIFO_DEPTH)
    else $error("too many requests in flight");

endmodule

bind if_stage if_stage_assertions u_if_stage_assertions (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .pc_set_i      (pc_set_i),
  .instr_req_o   (instr_req_o),
  .instr_addr_o  (instr_addr_o),
  .instr_gnt_i   (instr_gnt_i),
  .instr_rvalid_i(instr_rvalid_i)
);

`default_nettype wire

//--- test/tb_if_stage.sv
/*
 * Directed testbench for the fetch stage. A bus memory model answers
 * requests with address-derived words, the tests redirect and check decode.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_if_stage import if_pkg::*; ();

  localparam instr_t PATTERN   = 32'hA5C3_0F96;
  localparam addr_t  ERR_ADDR  = 32'h0000_2010;
  localparam int     NUM_TESTS = 5;

  logic        clk_i, rst_ni, req_i, pc_set_i, csr_mtvec_init_o;
  addr_t       boot_addr_i, branch_target_i, csr_mepc_i, csr_depc_i, csr_mtvec_i;
  pc_sel_e     pc_mux_i;
  exc_pc_sel_e exc_pc_mux_i;
  irq_id_t     exc_irq_id_i;
  logic        instr_req_o, instr_gnt_i, instr_rvalid_i, instr_bus_err_i;
  addr_t       instr_addr_o, pc_id_o, pc_if_o, mem_head;
  instr_t      instr_rdata_i, instr_rdata_id_o;
  logic        id_in_ready_i, instr_valid_clear_i, instr_valid_id_o, instr_new_id_o;
  logic        instr_fetch_err_o, if_busy_o, pc_mismatch_alert_o;
  int unsigned lcg_state;
  int unsigned gnt_wait;
  int          inflight;
  addr_t       pending_q [$];

  if_stage u_dut (.*);

  always #4 clk_i = ~clk_i;

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  //////////////////////////////////////////////////
  // bus memory model
  //////////////////////////////////////////////////

  // grant after 0..2 wait cycles, in-order response at least one cycle after grant
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_gnt_i    <= 1'b0;
      instr_rvalid_i <= 1'b0;
      gnt_wait        = 0;
      inflight        = 0;
      pending_q.delete();
    end else begin
      if (instr_req_o && instr_gnt_i) begin
        pending_q.push_back(instr_addr_o);
        gnt_wait = lcg_next() % 3;
      end else if (instr_req_o && gnt_wait > 0) begin
        gnt_wait = gnt_wait - 1;
      end
      instr_gnt_i <= (gnt_wait == 0);
      // granted and not yet answered during the coming cycle
      inflight = pending_q.size();
      // a single pending response is held back at random, two always drain the head
      if (inflight > 1 || (inflight == 1 && (lcg_next() % 2) == 0)) begin
        mem_head         = pending_q.pop_front();
        instr_rvalid_i  <= 1'b1;
        instr_rdata_i   <= mem_head ^ PATTERN;
        instr_bus_err_i <= (mem_head == ERR_ADDR);
      end else begin
        instr_rvalid_i  <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  task automatic report_failure(input string msg);
    $display("%0t: %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_addr(input addr_t got, input addr_t exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_instr(input instr_t got, input instr_t exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s got %b expected %b", $time, what, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  // alert must never fire on a clean stream, busy follows the responses still owed
  always @(negedge clk_i) begin
    if (rst_ni) begin
      check_bit(pc_mismatch_alert_o, 1'b0, "pc_mismatch_alert_o");
      check_bit(if_busy_o, inflight != 0, "if_busy_o");
    end
  end

  // redirect for one cycle, decode valid cleared alongside like a controller does
  task automatic redirect(input pc_sel_e sel, input exc_pc_sel_e esel, input irq_id_t id);
    @(posedge clk_i);
    pc_set_i            <= 1'b1;
    pc_mux_i            <= sel;
    exc_pc_mux_i        <= esel;
    exc_irq_id_i        <= id;
    instr_valid_clear_i <= 1'b1;
    @(negedge clk_i);
    check_bit(csr_mtvec_init_o, sel == PC_BOOT, "csr_mtvec_init_o");
    @(posedge clk_i);
    pc_set_i            <= 1'b0;
    instr_valid_clear_i <= 1'b0;
  endtask

  // expect count sequential instructions from start, optional random stalls
  task automatic collect_stream(input addr_t start, input int count, input bit stall);
    addr_t exp;
    int    got;
    int    idle;
    exp  = start;
    got  = 0;
    idle = 0;
    while (got < count) begin
      @(posedge clk_i);
      id_in_ready_i <= stall ? ((lcg_next() % 3) != 0) : 1'b1;
      @(negedge clk_i);
      if (instr_new_id_o) begin
        check_bit(instr_valid_id_o, 1'b1, "instr_valid_id_o");
        check_addr(pc_id_o, exp, "pc_id_o");
        check_instr(instr_rdata_id_o, exp ^ PATTERN, "instr_rdata_id_o");
        check_bit(instr_fetch_err_o, exp == ERR_ADDR, "instr_fetch_err_o");
        exp  = exp + INSTR_BYTES;
        got  = got + 1;
        idle = 0;
      end else begin
        idle = idle + 1;
        if (idle > 100) begin
          report_failure("no instruction reached decode within 100 cycles");
        end
      end
    end
    @(posedge clk_i);
    id_in_ready_i <= 1'b1;
  endtask

  // decode stalled, so the queue fills with the stream head and the bus goes quiet
  task automatic expect_full_queue(input addr_t head);
    int wait_cycles;
    wait_cycles = 0;
    @(negedge clk_i);
    while (instr_req_o || if_busy_o) begin
      wait_cycles = wait_cycles + 1;
      if (wait_cycles > 50) begin
        report_failure("fetch did not stop while decode was stalled");
      end
      @(negedge clk_i);
    end
    repeat (4) begin
      check_bit(instr_req_o, 1'b0, "instr_req_o with full queue");
      check_bit(instr_new_id_o, 1'b0, "instr_new_id_o while stalled");
      check_addr(pc_if_o, head, "pc_if_o");
      @(negedge clk_i);
    end
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////

  task automatic test_boot();
    @(negedge clk_i);
    check_bit(instr_req_o, 1'b0, "instr_req_o before boot");
    check_bit(instr_valid_id_o, 1'b0, "instr_valid_id_o after reset");
    check_bit(instr_new_id_o, 1'b0, "instr_new_id_o after reset");
    redirect(PC_BOOT, EXC_PC_EXC, '0);
    collect_stream((boot_addr_i & 32'hFFFF_FF00) + 32'h80, 6, 1'b0);
  endtask

  task automatic test_traps();
    addr_t base;
    irq_id_t ids [3];
    base = csr_mtvec_i & 32'hFFFF_FF00;
    ids  = '{5'd0, 5'd5, 5'd31};
    redirect(PC_EXC, EXC_PC_EXC, '0);
    collect_stream(base, 3, 1'b0);
    foreach (ids[i]) begin
      redirect(PC_EXC, EXC_PC_IRQ, ids[i]);
      collect_stream(base + 4 * ids[i], 3, 1'b0);
    end
    redirect(PC_EXC, EXC_PC_DBD, '0);
    collect_stream(32'h1A11_0800, 3, 1'b0);
    redirect(PC_EXC, EXC_PC_DBG_EXC, '0);
    collect_stream(32'h1A11_0808, 3, 1'b0);
  endtask

  // a wrong first PC here would be a stale word from the old stream
  task automatic test_returns();
    redirect(PC_ERET, EXC_PC_EXC, '0);
    collect_stream(csr_mepc_i, 4, 1'b0);
    redirect(PC_DRET, EXC_PC_EXC, '0);
    collect_stream(csr_depc_i, 4, 1'b0);
    redirect(PC_JUMP, EXC_PC_EXC, '0);
    collect_stream(branch_target_i, 4, 1'b0);
  endtask

  task automatic test_backpressure();
    @(posedge clk_i);
    branch_target_i <= 32'h0000_7000;
    id_in_ready_i   <= 1'b0;
    redirect(PC_JUMP, EXC_PC_EXC, '0);
    expect_full_queue(32'h0000_7000);
    collect_stream(32'h0000_7000, 20, 1'b1);
  endtask

  task automatic test_error_clear();
    @(posedge clk_i);
    branch_target_i <= 32'h0000_2000;
    redirect(PC_JUMP, EXC_PC_EXC, '0);
    collect_stream(32'h0000_2000, 8, 1'b0);
    @(posedge clk_i);
    id_in_ready_i       <= 1'b0;
    instr_valid_clear_i <= 1'b1;
    @(posedge clk_i);
    instr_valid_clear_i <= 1'b0;
    @(negedge clk_i);
    check_bit(instr_valid_id_o, 1'b0, "instr_valid_id_o after clear");
    @(posedge clk_i);
    id_in_ready_i <= 1'b1;
  endtask

  // watchdog, 200 cycles per test
  initial begin
    #(NUM_TESTS * 200 * 8);
    $display("watchdog expired before the tests finished");
    $display("TEST FAILED");
    $fatal(1);
  end

  initial begin
    clk_i               = 1'b0;
    rst_ni              = 1'b0;
    lcg_state           = 45854;
    inflight            = 0;
    req_i               = 1'b1;
    pc_set_i            = 1'b0;
    pc_mux_i            = PC_BOOT;
    exc_pc_mux_i        = EXC_PC_EXC;
    exc_irq_id_i        = '0;
    boot_addr_i         = 32'h0000_1055;
    branch_target_i     = 32'h0000_6008;
    csr_mepc_i          = 32'h0000_4000;
    csr_depc_i          = 32'h0000_5004;
    csr_mtvec_i         = 32'h0000_3045;
    id_in_ready_i       = 1'b1;
    instr_valid_clear_i = 1'b0;
    instr_gnt_i         = 1'b0;
    instr_rvalid_i      = 1'b0;
    instr_rdata_i       = '0;
    instr_bus_err_i     = 1'b0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    test_boot();
    test_traps();
    test_returns();
    test_backpressure();
    test_error_clear();
    repeat (4) @(posedge clk_i);
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
design/if_pkg.sv
design/pc_select.sv
design/fetch_unit.sv
design/fetch_fifo.sv
design/if_id_reg.sv
design/pc_check.sv
design/if_stage.sv
test/if_stage_assertions.sv
test/tb_if_stage.sv

//--- Makefile
SRCS := $(shell cat files.f)

.PHONY: run clean

obj_dir/Vtb_if_stage: $(SRCS) files.f
	verilator --binary --timing --assert --top-module tb_if_stage \
		-f files.f --Mdir obj_dir -o Vtb_if_stage

run: obj_dir/Vtb_if_stage
	./obj_dir/Vtb_if_stage | tee sim.log
	@grep -q "TEST OK" sim.log
	@! grep -q "TEST FAILED" sim.log

clean:
	rm -rf obj_dir sim.log
